// ==== verilog.f ====
+incdir+design
design/mips_pkg.sv
design/alu.sv
design/reg_file.sv
design/datapath.sv
design/bus_timer.sv
design/main_decoder.sv
design/mips_core.sv
test/mem_responder.sv
test/mips_core_asserts.sv
test/mips_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = mips_core_tb
FILELIST = verilog.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core_tb
	import mips_pkg::*;
();

	localparam word_t stop_word = 32'hfc00_0000;  // Opcode 6'h3f is undefined
	localparam int halt_limit = 40 * `MIPS_BUS_TIMEOUT;

	logic  clk;
	logic  reset;
	logic  muted;
	logic  mem_req;
	logic  mem_we;
	word_t mem_addr;
	word_t mem_wdata;
	logic  mem_ack;
	word_t mem_rdata;
	logic  halted;
	logic  bus_fault;

	string cur_test;
	int    checks = 0;
	int    errors = 0;
	int    errors_before = 0;
	int    tests_run = 0;
	int    tests_failed = 0;

	mips_core u_dut (
		.clk       (clk),
		.reset     (reset),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.halted    (halted),
		.bus_fault (bus_fault)
	);

	mem_responder u_mem (
		.clk   (clk),
		.reset (reset),
		.muted (muted),
		.req   (mem_req),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.ack   (mem_ack),
		.rdata (mem_rdata)
	);

	always #4 clk = ~clk;

	function automatic word_t r_instr(input funct_t fn, input reg_addr_t rs,
		input reg_addr_t rt, input reg_addr_t rd);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_instr(input opcode_t op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_instr(input opcode_t op, input logic [25:0] target);
		return {op, target};  // Word index of the target
	endfunction

	function automatic word_t sign_ext(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t zero_ext(input logic [15:0] v);
		return {16'd0, v};
	endfunction

	task automatic check_word(input string what, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s (%s): expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s (%s): expected %b, actual %b", cur_test, what, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("ERROR %s: %s", cur_test, msg);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		errors_before = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors > errors_before) begin
			tests_failed++;
			$display("%s: failed with %0d errors", cur_test, errors - errors_before);
		end else begin
			$display("%s: passed", cur_test);
		end
	endtask

	// Core stays in reset while memory is rewritten
	task automatic load_program(input word_t prog[$]);
		@(posedge clk);
		#1;
		reset = 1'b1;
		u_mem.clear_memory();
		foreach (prog[i])
			u_mem.write_word(word_t'(i) << 2, prog[i]);
	endtask

	task automatic start_core();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic wait_halt(output int cycles);
		cycles = 0;
		while (!halted && cycles < halt_limit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!halted)
			report_failure("core did not halt within the cycle limit");
	endtask

	task automatic check_idle();
		logic seen;
		seen = 1'b0;
		repeat (20) begin
			@(posedge clk);
			#1;
			seen = seen | mem_req;
		end
		check_flag("request after halt", 1'b0, seen);
	endtask

	task automatic expect_clean_halt();
		int cycles;
		wait_halt(cycles);
		check_flag("halted", 1'b1, halted);
		check_flag("bus_fault", 1'b0, bus_fault);
		check_idle();
	endtask

	task automatic arith_test();
		word_t prog[$];
		word_t exp_val [10];
		word_t r1;
		word_t r2;
		begin_test("arith");
		prog = '{
			i_instr(op_lui,   5'd0, 5'd1, 16'h1234),
			i_instr(op_ori,   5'd1, 5'd1, 16'h8765),
			i_instr(op_addiu, 5'd0, 5'd2, 16'hfed4),
			r_instr(fn_addu,  5'd1, 5'd2, 5'd3),
			r_instr(fn_subu,  5'd1, 5'd2, 5'd4),
			r_instr(fn_and,   5'd1, 5'd2, 5'd5),
			r_instr(fn_or,    5'd1, 5'd2, 5'd6),
			r_instr(fn_slt,   5'd2, 5'd1, 5'd7),
			i_instr(op_slti,  5'd1, 5'd8, 16'hffff),
			i_instr(op_andi,  5'd2, 5'd9, 16'hff0f),
			i_instr(op_addiu, 5'd1, 5'd0, 16'h0005)  // Lost on register zero
		};
		for (int i = 0; i < 10; i++)
			prog.push_back(i_instr(op_sw, 5'd0, reg_addr_t'((i + 1) % 10),
				16'(32'h200 + 4 * i)));
		prog.push_back(stop_word);
		r1 = {16'h1234, 16'h0000} | zero_ext(16'h8765);
		r2 = sign_ext(16'hfed4);
		exp_val[0] = r1;
		exp_val[1] = r2;
		exp_val[2] = r1 + r2;
		exp_val[3] = r1 - r2;
		exp_val[4] = r1 & r2;
		exp_val[5] = r1 | r2;
		exp_val[6] = ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0;
		exp_val[7] = ($signed(r1) < $signed(sign_ext(16'hffff))) ? 32'd1 : 32'd0;
		exp_val[8] = r2 & zero_ext(16'hff0f);
		exp_val[9] = 32'd0;
		load_program(prog);
		start_core();
		expect_clean_halt();
		for (int i = 0; i < 10; i++)
			check_word($sformatf("store %0d", i), exp_val[i],
				u_mem.read_word(word_t'(32'h200 + 4 * i)));
		end_test();
	endtask

	task automatic load_store_test();
		word_t prog[$];
		word_t d0;
		word_t d1;
		begin_test("load_store");
		d0 = 32'h0000_1111;
		d1 = 32'h8000_0001;
		prog = '{
			i_instr(op_addiu, 5'd0,  5'd10, 16'h0300),
			i_instr(op_lw,    5'd10, 5'd11, 16'h0000),
			i_instr(op_lw,    5'd10, 5'd12, 16'h0004),
			r_instr(fn_addu,  5'd11, 5'd12, 5'd13),
			i_instr(op_addiu, 5'd12, 5'd14, 16'hfffe),
			i_instr(op_sw,    5'd10, 5'd13, 16'h0040),
			i_instr(op_sw,    5'd10, 5'd14, 16'h0044),
			i_instr(op_lw,    5'd10, 5'd15, 16'h0040),
			i_instr(op_sw,    5'd10, 5'd15, 16'hfff8),  // Negative offset
			stop_word
		};
		load_program(prog);
		u_mem.write_word(32'h300, d0);
		u_mem.write_word(32'h304, d1);
		start_core();
		expect_clean_halt();
		check_word("sum", d0 + d1, u_mem.read_word(32'h340));
		check_word("decrement", d1 + sign_ext(16'hfffe), u_mem.read_word(32'h344));
		check_word("reload", d0 + d1, u_mem.read_word(32'h2f8));
		end_test();
	endtask

	task automatic branch_test();
		word_t prog[$];
		word_t marker;
		begin_test("branch");
		marker = zero_ext(16'h00a1);
		prog = '{
			i_instr(op_addiu, 5'd0, 5'd1,  16'h0007),
			i_instr(op_addiu, 5'd0, 5'd2,  16'h0007),
			i_instr(op_addiu, 5'd0, 5'd3,  16'h0009),
			i_instr(op_addiu, 5'd0, 5'd20, 16'h00a1),
			i_instr(op_beq,   5'd1, 5'd2,  16'h0001),  // Taken
			i_instr(op_sw,    5'd0, 5'd20, 16'h0200),
			i_instr(op_sw,    5'd0, 5'd20, 16'h0204),
			i_instr(op_beq,   5'd1, 5'd3,  16'h0001),  // Not taken
			i_instr(op_sw,    5'd0, 5'd20, 16'h0208),
			i_instr(op_bne,   5'd1, 5'd3,  16'h0001),  // Taken
			i_instr(op_sw,    5'd0, 5'd20, 16'h020c),
			i_instr(op_bne,   5'd1, 5'd2,  16'h0001),  // Not taken
			i_instr(op_sw,    5'd0, 5'd20, 16'h0210),
			stop_word
		};
		load_program(prog);
		start_core();
		expect_clean_halt();
		check_word("beq taken skip", u_mem.fill_value(32'h200), u_mem.read_word(32'h200));
		check_word("beq taken target", marker, u_mem.read_word(32'h204));
		check_word("beq fall through", marker, u_mem.read_word(32'h208));
		check_word("bne taken skip", u_mem.fill_value(32'h20c), u_mem.read_word(32'h20c));
		check_word("bne fall through", marker, u_mem.read_word(32'h210));
		end_test();
	endtask

	task automatic jump_test();
		word_t prog[$];
		word_t marker;
		begin_test("jump");
		marker = zero_ext(16'h005a);
		prog = '{
			i_instr(op_addiu, 5'd0,  5'd21, 16'h005a),
			j_instr(op_j,     26'd3),
			i_instr(op_sw,    5'd0,  5'd21, 16'h0200),  // Skipped
			i_instr(op_sw,    5'd0,  5'd21, 16'h0204),
			j_instr(op_jal,   26'd7),                   // At byte address 0x10
			i_instr(op_sw,    5'd0,  5'd31, 16'h0208),
			stop_word,
			i_instr(op_sw,    5'd0,  5'd21, 16'h020c),
			r_instr(fn_jr,    5'd31, 5'd0,  5'd0)
		};
		load_program(prog);
		start_core();
		expect_clean_halt();
		check_word("j skip", u_mem.fill_value(32'h200), u_mem.read_word(32'h200));
		check_word("j target", marker, u_mem.read_word(32'h204));
		check_word("link register", 32'h10 + 32'd4, u_mem.read_word(32'h208));
		check_word("subroutine", marker, u_mem.read_word(32'h20c));
		end_test();
	endtask

	task automatic illegal_test();
		word_t prog[$];
		begin_test("illegal");
		prog = '{
			i_instr(op_addiu, 5'd0, 5'd1, 16'h0077),
			i_instr(op_sw,    5'd0, 5'd1, 16'h0200),
			r_instr(6'h3f,    5'd1, 5'd1, 5'd1),  // Undefined funct
			i_instr(op_sw,    5'd0, 5'd1, 16'h0204)
		};
		load_program(prog);
		start_core();
		expect_clean_halt();
		check_word("before halt", zero_ext(16'h0077), u_mem.read_word(32'h200));
		check_word("after halt", u_mem.fill_value(32'h204), u_mem.read_word(32'h204));
		end_test();
	endtask

	task automatic timeout_test();
		word_t prog[$];
		int    cycles;
		begin_test("timeout");
		prog = '{
			i_instr(op_addiu, 5'd0, 5'd1, 16'h0001),
			stop_word
		};
		load_program(prog);
		muted = 1'b1;  // First fetch never gets its ack
		start_core();
		wait_halt(cycles);
		check_flag("halted", 1'b1, halted);
		check_flag("bus_fault", 1'b1, bus_fault);
		check_flag("waited the full limit", 1'b1, cycles >= `MIPS_BUS_TIMEOUT);
		check_idle();
		muted = 1'b0;
		end_test();
	endtask

	initial begin
		void'($urandom(32'h72a4_448b));
		clk = 1'b0;
		reset = 1'b1;
		muted = 1'b0;
		arith_test();
		load_store_test();
		branch_test();
		jump_test();
		illegal_test();
		timeout_test();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/mips_core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_asserts
	import mips_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input logic  mem_req,
	input logic  mem_we,
	input word_t mem_addr,
	input word_t mem_wdata,
	input logic  mem_ack,
	input logic  halted
);

	// Only a bus timeout may end a request without its ack
	req_held: assert property (@(posedge clk) disable iff (reset)
		mem_req && !mem_ack |=> mem_req || halted)
		else $error("request dropped before ack");

	req_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req && !mem_ack |=> !mem_req ||
			($stable(mem_addr) && $stable(mem_we) && (!mem_we || $stable(mem_wdata))))
		else $error("request fields changed while waiting for ack");

	req_after_release: assert property (@(posedge clk) disable iff (reset)
		$rose(mem_req) |-> !mem_ack)
		else $error("new request raised while ack still high");

	halt_quiet: assert property (@(posedge clk) disable iff (reset)
		halted |-> !mem_req ##1 halted)
		else $error("request or restart after halt");

endmodule

bind mips_core mips_core_asserts u_asserts (
	.clk       (clk),
	.reset     (reset),
	.mem_req   (mem_req),
	.mem_we    (mem_we),
	.mem_addr  (mem_addr),
	.mem_wdata (mem_wdata),
	.mem_ack   (mem_ack),
	.halted    (halted)
);

`default_nettype wire

// ==== test/mem_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_responder
	import mips_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  muted,
	input  logic  req,
	input  logic  we,
	input  word_t addr,
	input  word_t wdata,
	output logic  ack,
	output word_t rdata
);

	localparam int words = 256;  // 1 KB, byte addresses 0x000 to 0x3ff

	word_t       mem [words];
	logic        ack_q = 1'b0;
	word_t       rdata_q = '0;
	logic        pending = 1'b0;
	int unsigned delay_left = 0;
	logic        reset_s;
	logic        muted_s;
	logic        req_s;
	logic        we_s;
	word_t       addr_s;
	word_t       wdata_s;

	assign ack = ack_q;
	assign rdata = rdata_q;

	// Inputs sampled on the edge, answer driven 1 ns later
	always @(posedge clk) begin
		reset_s = reset;
		muted_s = muted;
		req_s = req;
		we_s = we;
		addr_s = addr;
		wdata_s = wdata;
		#1;
		if (reset_s) begin
			ack_q = 1'b0;
			pending = 1'b0;
		end else if (!muted_s && (req_s != ack_q)) begin
			if (!pending) begin
				pending = 1'b1;
				delay_left = $urandom_range(5, 0);  // New delay for each phase
			end
			if (delay_left != 0) begin
				delay_left--;
			end else begin
				pending = 1'b0;
				if (req_s && we_s)
					mem[addr_s[9:2]] = wdata_s;
				else if (req_s)
					rdata_q = mem[addr_s[9:2]];
				ack_q = req_s;  // Raise on a request, drop on its release
			end
		end
	end

	// Every unwritten word decodes as an undefined opcode
	function automatic word_t fill_value(input word_t a);
		return ~a;
	endfunction

	task automatic clear_memory();
		word_t a;
		for (a = '0; a < 32'h400; a += 32'd4)
			mem[a[9:2]] = fill_value(a);
	endtask

	task automatic write_word(input word_t a, input word_t data);
		mem[a[9:2]] = data;
	endtask

	function automatic word_t read_word(input word_t a);
		return mem[a[9:2]];
	endfunction

endmodule

`default_nettype wire

// ==== design/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core
	import mips_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	output logic  mem_req,
	output logic  mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input  logic  mem_ack,
	input  word_t mem_rdata,
	output logic  halted,
	output logic  bus_fault
);

	opcode_t    opcode;
	funct_t     funct;
	logic       zero;
	logic       waiting;
	logic       timeout;
	logic       pc_write;
	logic       ir_write;
	logic       mdr_write;
	logic       reg_write;
	logic       reg_dst_rd;
	logic       reg_dst_ra;
	logic       mem_to_reg;
	logic       alu_src_a;
	logic [1:0] alu_src_b;
	alu_op_t    alu_op;
	logic [1:0] pc_src;

	main_decoder u_decoder (
		.clk        (clk),
		.reset      (reset),
		.opcode     (opcode),
		.funct      (funct),
		.zero       (zero),
		.mem_ack    (mem_ack),
		.timeout    (timeout),
		.mem_req    (mem_req),
		.mem_we     (mem_we),
		.waiting    (waiting),
		.pc_write   (pc_write),
		.ir_write   (ir_write),
		.mdr_write  (mdr_write),
		.reg_write  (reg_write),
		.reg_dst_rd (reg_dst_rd),
		.reg_dst_ra (reg_dst_ra),
		.mem_to_reg (mem_to_reg),
		.alu_src_a  (alu_src_a),
		.alu_src_b  (alu_src_b),
		.alu_op     (alu_op),
		.pc_src     (pc_src),
		.halted     (halted),
		.bus_fault  (bus_fault)
	);

	bus_timer u_timer (
		.clk     (clk),
		.reset   (reset),
		.waiting (waiting),
		.timeout (timeout)
	);

	datapath u_datapath (
		.clk        (clk),
		.reset      (reset),
		.pc_write   (pc_write),
		.ir_write   (ir_write),
		.mdr_write  (mdr_write),
		.reg_write  (reg_write),
		.reg_dst_rd (reg_dst_rd),
		.reg_dst_ra (reg_dst_ra),
		.mem_to_reg (mem_to_reg),
		.alu_src_a  (alu_src_a),
		.alu_src_b  (alu_src_b),
		.alu_op     (alu_op),
		.pc_src     (pc_src),
		.mem_rdata  (mem_rdata),
		.opcode     (opcode),
		.funct      (funct),
		.zero       (zero),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

endmodule

`default_nettype wire

// ==== design/main_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_decoder
	import mips_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  opcode_t     opcode,
	input  funct_t      funct,
	input  logic        zero,
	input  logic        mem_ack,
	input  logic        timeout,
	output logic        mem_req,
	output logic        mem_we,
	output logic        waiting,
	output logic        pc_write,
	output logic        ir_write,
	output logic        mdr_write,
	output logic        reg_write,
	output logic        reg_dst_rd,
	output logic        reg_dst_ra,
	output logic        mem_to_reg,
	output logic        alu_src_a,
	output logic [1:0]  alu_src_b,
	output alu_op_t     alu_op,
	output logic [1:0]  pc_src,
	output logic        halted,
	output logic        bus_fault
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	alu_op_t     exec_op;
	logic        legal;
	logic        branch_taken;
	logic        fault_set;

	// Instruction decode into an ALU operation, flags unknown encodings
	always_comb begin
		legal = 1'b1;
		exec_op = alu_add;
		case (opcode)
			op_rtype: begin
				case (funct)
					fn_addu, fn_jr: exec_op = alu_add;
					fn_subu:        exec_op = alu_sub;
					fn_and:         exec_op = alu_and;
					fn_or:          exec_op = alu_or;
					fn_slt:         exec_op = alu_slt;
					default:        legal = 1'b0;
				endcase
			end
			op_addiu, op_lw, op_sw, op_j, op_jal: exec_op = alu_add;
			op_andi:        exec_op = alu_and;
			op_ori:         exec_op = alu_or;
			op_slti:        exec_op = alu_slt;
			op_lui:         exec_op = alu_lui;
			op_beq, op_bne: exec_op = alu_sub;
			default:        legal = 1'b0;
		endcase
	end

	assign branch_taken = (opcode == op_bne) ? !zero : zero;

	always_comb begin
		state_next = state;
		waiting = 1'b0;
		pc_write = 1'b0;
		ir_write = 1'b0;
		mdr_write = 1'b0;
		reg_write = 1'b0;
		reg_dst_rd = 1'b0;
		reg_dst_ra = 1'b0;
		mem_to_reg = 1'b0;
		alu_src_a = 1'b0;
		alu_src_b = 2'd0;
		alu_op = alu_add;
		pc_src = 2'd0;
		fault_set = 1'b0;
		case (state)
			st_fetch_req: begin
				waiting = !(mem_req && mem_ack);
				if (mem_req && mem_ack) begin
					ir_write = 1'b1;     // Latch instruction
					pc_write = 1'b1;     // PC + 4
					state_next = st_fetch_release;
				end else if (timeout) begin
					fault_set = 1'b1;
					state_next = st_halted;
				end
			end
			st_fetch_release: begin
				waiting = mem_ack;
				if (!mem_ack) begin
					state_next = st_decode;
				end else if (timeout) begin
					fault_set = 1'b1;
					state_next = st_halted;
				end
			end
			st_decode: begin
				alu_src_b = 2'd2;        // Branch target into alu_out
				state_next = legal ? st_execute : st_halted;
			end
			st_execute: begin
				alu_op = exec_op;
				alu_src_a = 1'b1;
				case (opcode)
					op_rtype: begin
						if (funct == fn_jr) begin
							pc_write = 1'b1;
							pc_src = 2'd3;
							state_next = st_fetch_req;
						end else begin
							state_next = st_writeback;
						end
					end
					op_addiu, op_andi, op_ori, op_slti, op_lui: begin
						alu_src_b = 2'd1;
						state_next = st_writeback;
					end
					op_lw, op_sw: begin
						alu_src_b = 2'd1;    // Effective address
						state_next = st_mem_req;
					end
					op_beq, op_bne: begin
						pc_write = branch_taken;
						pc_src = 2'd1;
						state_next = st_fetch_req;
					end
					op_j: begin
						pc_write = 1'b1;
						pc_src = 2'd2;
						state_next = st_fetch_req;
					end
					op_jal: begin
						alu_src_a = 1'b0;    // Link value is PC + 0
						alu_src_b = 2'd3;
						pc_write = 1'b1;
						pc_src = 2'd2;
						state_next = st_writeback;
					end
					default: state_next = st_halted;
				endcase
			end
			st_mem_req: begin
				alu_src_a = 1'b1;        // Hold address in alu_out
				alu_src_b = 2'd1;
				waiting = !(mem_req && mem_ack);
				if (mem_req && mem_ack) begin
					mdr_write = (opcode == op_lw);
					state_next = st_mem_release;
				end else if (timeout) begin
					fault_set = 1'b1;
					state_next = st_halted;
				end
			end
			st_mem_release: begin
				alu_src_a = 1'b1;
				alu_src_b = 2'd1;
				waiting = mem_ack;
				if (!mem_ack) begin
					state_next = (opcode == op_lw) ? st_writeback : st_fetch_req;
				end else if (timeout) begin
					fault_set = 1'b1;
					state_next = st_halted;
				end
			end
			st_writeback: begin
				reg_write = 1'b1;
				reg_dst_rd = (opcode == op_rtype);
				reg_dst_ra = (opcode == op_jal);
				mem_to_reg = (opcode == op_lw);
				state_next = st_fetch_req;
			end
			st_halted: state_next = st_halted;  // Only reset leaves here
			default:   state_next = st_halted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_fetch_req;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			bus_fault <= 1'b0;
		end else begin
			state <= state_next;
			mem_req <= (state_next == st_fetch_req) || (state_next == st_mem_req);
			mem_we <= (state_next == st_mem_req) && (opcode == op_sw);
			bus_fault <= bus_fault || fault_set;
		end
	end

	assign halted = (state == st_halted);

endmodule

`default_nettype wire

// ==== design/bus_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module bus_timer #(
	parameter int LIMIT = `MIPS_BUS_TIMEOUT
) (
	input  logic clk,
	input  logic reset,
	input  logic waiting,
	output logic timeout
);

	localparam int CW = $clog2(LIMIT + 1);

	logic [CW-1:0] count;

	// Restarts on every completed phase, saturates at LIMIT
	always_ff @(posedge clk) begin
		if (reset || !waiting) begin
			count <= '0;
			timeout <= 1'b0;
		end else begin
			if (count != CW'(LIMIT))
				count <= count + 1'b1;
			timeout <= (count == CW'(LIMIT - 1));  // Single pulse at LIMIT
		end
	end

endmodule

`default_nettype wire

// ==== design/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module datapath
	import mips_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       pc_write,
	input  logic       ir_write,
	input  logic       mdr_write,
	input  logic       reg_write,
	input  logic       reg_dst_rd,
	input  logic       reg_dst_ra,
	input  logic       mem_to_reg,
	input  logic       alu_src_a,
	input  logic [1:0] alu_src_b,
	input  alu_op_t    alu_op,
	input  logic [1:0] pc_src,
	input  word_t      mem_rdata,
	output opcode_t    opcode,
	output funct_t     funct,
	output logic       zero,
	output word_t      mem_addr,
	output word_t      mem_wdata
);

	word_t     pc;
	word_t     ir;
	word_t     mdr;
	word_t     a_reg;
	word_t     b_reg;
	word_t     alu_out;
	word_t     pc_next;
	word_t     rd1;
	word_t     rd2;
	word_t     imm_ext;
	word_t     src_a;
	word_t     src_b;
	word_t     alu_result;
	word_t     wd;
	reg_addr_t wa;

	assign opcode = ir[31:26];
	assign funct = ir[5:0];

	// andi and ori take a zero-extended immediate
	assign imm_ext = ((opcode == op_andi) || (opcode == op_ori))
		? {16'd0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

	assign wa = reg_dst_ra ? 5'd31 : (reg_dst_rd ? ir[15:11] : ir[20:16]);
	assign wd = mem_to_reg ? mdr : alu_out;

	reg_file u_reg_file (
		.clk (clk),
		.ra1 (ir[25:21]),
		.ra2 (ir[20:16]),
		.wa  (wa),
		.we  (reg_write),
		.wd  (wd),
		.rd1 (rd1),
		.rd2 (rd2)
	);

	assign src_a = alu_src_a ? a_reg : pc;

	always_comb begin
		case (alu_src_b)
			2'd0:    src_b = b_reg;
			2'd1:    src_b = imm_ext;
			2'd2:    src_b = {imm_ext[29:0], 2'b00};  // Word offset of a branch
			default: src_b = '0;
		endcase
	end

	alu u_alu (
		.a      (src_a),
		.b      (src_b),
		.op     (alu_op),
		.result (alu_result),
		.zero   (zero)
	);

	always_comb begin
		case (pc_src)
			2'd0:    pc_next = pc + 32'd4;
			2'd1:    pc_next = alu_out;                       // Branch target
			2'd2:    pc_next = {pc[31:28], ir[25:0], 2'b00};  // j and jal
			default: pc_next = a_reg;                         // jr
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `MIPS_RESET_PC;
		else if (pc_write)
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (ir_write)
			ir <= mem_rdata;
		if (mdr_write)
			mdr <= mem_rdata;
		a_reg <= rd1;
		b_reg <= rd2;
		alu_out <= alu_result;
	end

	// Data accesses always address through alu_out
	assign mem_addr = alu_src_a ? alu_out : pc;
	assign mem_wdata = b_reg;

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module reg_file
	import mips_pkg::*;
(
	input  logic      clk,
	input  reg_addr_t ra1,
	input  reg_addr_t ra2,
	input  reg_addr_t wa,
	input  logic      we,
	input  word_t     wd,
	output word_t     rd1,
	output word_t     rd2
);

	word_t regs [`MIPS_NUM_REGS];

	always_ff @(posedge clk) begin
		if (we && (wa != '0))  // Register zero is read-only
			regs[wa] <= wd;
	end

	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import mips_pkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  alu_op_t op,
	output word_t   result,
	output logic    zero
);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {31'd0, $signed(a) < $signed(b)};  // Signed compare
			alu_lui: result = {b[15:0], 16'd0};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);  // Used by beq and bne

endmodule

`default_nettype wire

// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;      // Data and address word
	typedef logic [4:0]  reg_addr_t;  // Register index
	typedef logic [5:0]  opcode_t;    // Instruction bits 31:26
	typedef logic [5:0]  funct_t;     // Instruction bits 5:0

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_t;

	typedef enum logic [3:0] {
		st_fetch_req,
		st_fetch_wait,    // Kept for encoding, fetch_req covers the ack wait
		st_fetch_release,
		st_decode,
		st_execute,
		st_mem_req,
		st_mem_wait,
		st_mem_release,
		st_writeback,
		st_halted
	} ctrl_state_t;

	localparam opcode_t op_rtype = 6'b000000;
	localparam opcode_t op_j     = 6'b000010;
	localparam opcode_t op_jal   = 6'b000011;
	localparam opcode_t op_beq   = 6'b000100;
	localparam opcode_t op_bne   = 6'b000101;
	localparam opcode_t op_addiu = 6'b001001;
	localparam opcode_t op_slti  = 6'b001010;
	localparam opcode_t op_andi  = 6'b001100;
	localparam opcode_t op_ori   = 6'b001101;
	localparam opcode_t op_lui   = 6'b001111;
	localparam opcode_t op_lw    = 6'b100011;
	localparam opcode_t op_sw    = 6'b101011;

	localparam funct_t fn_jr   = 6'b001000;
	localparam funct_t fn_addu = 6'b100001;
	localparam funct_t fn_subu = 6'b100011;
	localparam funct_t fn_and  = 6'b100100;
	localparam funct_t fn_or   = 6'b100101;
	localparam funct_t fn_slt  = 6'b101010;

endpackage

`default_nettype wire

// ==== design/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Core build options

`define MIPS_RESET_PC    32'h0000_0000  // Byte address of first fetch

`define MIPS_BUS_TIMEOUT 64             // Cycles one handshake phase may last

`define MIPS_NUM_REGS    32             // General purpose registers

`endif
